//--- common/fp_issue_settings.svh
// fp issue settings for downstream slot count and float register count
`ifndef FP_ISSUE_SETTINGS_SVH
`define FP_ISSUE_SETTINGS_SVH

////////////////////
// downstream FP unit

// free slots after reset
`define FP_CREDITS 4

////////////////////
// register file

`define FP_REG_COUNT 32

`endif

//--- common/fp_issue_pkg.sv
// fp issue package with the op class, format and state enums and the decode, issue and writeback structs
`default_nettype none

package fp_issue_pkg;

    ////////////////////
    // enums

    // major opcode group of an FP instruction
    typedef enum logic [1:0] {
        OPC_LOAD,
        OPC_STORE,
        OPC_FMA,
        OPC_OP
    } fp_op_class_e;

    // precision taken from the fmt field, or from funct3 for loads and stores
    typedef enum logic {
        FMT_S,
        FMT_D
    } fp_fmt_e;

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_HELD,
        ST_TRAP
    } fp_issue_state_e;

    ////////////////////
    // structs

    typedef struct packed {
        logic         legal;
        fp_op_class_e op_class;
        fp_fmt_e      fmt;
        logic         need_int;
        logic         need_float;
        logic         write_int;
        logic         write_float;
        logic         accum_csr;
        // fused ops read a third float source
        logic         uses_rs3;
    } fp_decode_t;

    typedef struct packed {
        logic [31:0]  instr;
        fp_op_class_e op_class;
        fp_fmt_e      fmt;
        logic         need_int;
        logic         need_float;
        logic         write_int;
        logic         write_float;
        logic         accum_csr;
    } fp_issue_pkt_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       is_float;
    } fp_wb_t;

endpackage

`default_nettype wire

//--- hdl/fp_instruction_decoder.sv
// fp instruction decoder checking RV32F/D legality and classifying operands of one word
`timescale 1ns/1ps
`default_nettype none

module fp_instruction_decoder (
    input  logic [31:0]              instr,
    output fp_issue_pkg::fp_decode_t dec
);

    ////////////////////
    // encoding table
    // fields are funct5_fmt_rs2_rs1_funct3_rd_opcode
    // fmt bit 25 is a wildcard so one entry covers .S and .D, bit 26 rules out H and Q
    localparam logic [31:0] P_LOAD    = 32'b?????_??_?????_?????_01?_?????_0000111;
    localparam logic [31:0] P_STORE   = 32'b?????_??_?????_?????_01?_?????_0100111;
    localparam logic [31:0] P_FMA     = 32'b?????_0?_?????_?????_???_?????_100??11;
    localparam logic [31:0] P_ARITH   = 32'b000??_0?_?????_?????_???_?????_1010011;
    localparam logic [31:0] P_SQRT    = 32'b01011_0?_00000_?????_???_?????_1010011;
    localparam logic [31:0] P_SGNJ_A  = 32'b00100_0?_?????_?????_00?_?????_1010011;
    localparam logic [31:0] P_SGNJ_B  = 32'b00100_0?_?????_?????_010_?????_1010011;
    localparam logic [31:0] P_MINMAX  = 32'b00101_0?_?????_?????_00?_?????_1010011;
    localparam logic [31:0] P_CMP_A   = 32'b10100_0?_?????_?????_00?_?????_1010011;
    localparam logic [31:0] P_CMP_B   = 32'b10100_0?_?????_?????_010_?????_1010011;
    localparam logic [31:0] P_CVT_I_F = 32'b11000_0?_0000?_?????_???_?????_1010011;
    localparam logic [31:0] P_CVT_F_I = 32'b11010_0?_0000?_?????_???_?????_1010011;
    localparam logic [31:0] P_MV_X_W  = 32'b11100_00_00000_?????_000_?????_1010011;
    localparam logic [31:0] P_CLASS   = 32'b11100_0?_00000_?????_001_?????_1010011;
    localparam logic [31:0] P_MV_W_X  = 32'b11110_00_00000_?????_000_?????_1010011;
    localparam logic [31:0] P_CVT_S_D = 32'b01000_00_00001_?????_???_?????_1010011;
    localparam logic [31:0] P_CVT_D_S = 32'b01000_01_00000_?????_???_?????_1010011;

    logic m_load, m_store, m_fma, m_arith, m_sqrt, m_sgnj, m_minmax, m_cmp;
    logic m_cvt_i_f, m_cvt_f_i, m_mv_x_w, m_class, m_mv_w_x, m_cvt_s_d, m_cvt_d_s;
    logic legal;
    logic fmt_d;
    logic write_int;

    assign m_load    = instr ==? P_LOAD;
    assign m_store   = instr ==? P_STORE;
    assign m_fma     = instr ==? P_FMA;
    assign m_arith   = instr ==? P_ARITH;
    assign m_sqrt    = instr ==? P_SQRT;
    assign m_sgnj    = (instr ==? P_SGNJ_A) || (instr ==? P_SGNJ_B);
    assign m_minmax  = instr ==? P_MINMAX;
    assign m_cmp     = (instr ==? P_CMP_A) || (instr ==? P_CMP_B);
    assign m_cvt_i_f = instr ==? P_CVT_I_F;
    assign m_cvt_f_i = instr ==? P_CVT_F_I;
    assign m_mv_x_w  = instr ==? P_MV_X_W;
    assign m_class   = instr ==? P_CLASS;
    assign m_mv_w_x  = instr ==? P_MV_W_X;
    assign m_cvt_s_d = instr ==? P_CVT_S_D;
    assign m_cvt_d_s = instr ==? P_CVT_D_S;

    assign legal = m_load | m_store | m_fma | m_arith | m_sqrt | m_sgnj | m_minmax | m_cmp |
                   m_cvt_i_f | m_cvt_f_i | m_mv_x_w | m_class | m_mv_w_x |
                   m_cvt_s_d | m_cvt_d_s;

    // loads and stores carry the width in funct3, everything else in fmt
    assign fmt_d = (m_load | m_store) ? instr[12] : instr[25];

    // results that land in the integer register file
    assign write_int = m_cmp | m_class | m_mv_x_w | m_cvt_i_f;

    ////////////////////
    // decode result
    always_comb begin
        dec.legal       = legal;
        dec.fmt         = fmt_d ? fp_issue_pkg::FMT_D : fp_issue_pkg::FMT_S;
        dec.need_int    = m_load | m_store | m_cvt_f_i | m_mv_w_x;
        dec.need_float  = m_store | m_fma | m_arith | m_sqrt | m_sgnj | m_minmax | m_cmp |
                          m_cvt_i_f | m_mv_x_w | m_class | m_cvt_s_d | m_cvt_d_s;
        dec.write_int   = write_int;
        dec.write_float = legal & ~m_store & ~write_int;
        dec.accum_csr   = (fmt_d & (m_fma | m_arith | m_sqrt | m_minmax | m_cmp | m_cvt_i_f)) |
                          m_cvt_s_d | m_cvt_d_s;
        dec.uses_rs3    = m_fma;
        if (m_load) begin
            dec.op_class = fp_issue_pkg::OPC_LOAD;
        end else if (m_store) begin
            dec.op_class = fp_issue_pkg::OPC_STORE;
        end else if (m_fma) begin
            dec.op_class = fp_issue_pkg::OPC_FMA;
        end else begin
            dec.op_class = fp_issue_pkg::OPC_OP;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fp_scoreboard.sv
// fp scoreboard tracking pending float destinations and flagging read and write hazards
`timescale 1ns/1ps
`default_nettype none
`include "fp_issue_settings.svh"

module fp_scoreboard (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [31:0]               instr,
    input  fp_issue_pkg::fp_decode_t  dec,
    input  logic                      issue,
    input  logic                      wb_valid,
    input  fp_issue_pkg::fp_wb_t      wb,
    output logic                      hazard
);

    logic [`FP_REG_COUNT-1:0] pending;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rs3;
    logic [4:0]               rd;
    logic                     src_busy;
    logic                     dst_busy;

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rs3 = instr[31:27];

    // a new write can never target a pending rd, so set and clear never collide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (wb_valid && wb.is_float) begin
                pending[wb.rd] <= 1'b0;
            end
            if (issue && dec.write_float) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // rs1/rs2 checked together even when one of them is an integer source
    assign src_busy = (dec.need_float && (pending[rs1] || pending[rs2])) ||
                      (dec.uses_rs3 && pending[rs3]);
    assign dst_busy = dec.write_float && pending[rd];
    assign hazard   = src_busy || dst_busy;

endmodule

`default_nettype wire

//--- hdl/fp_credit_counter.sv
// fp credit counter holding the number of free slots in the downstream FP unit
`timescale 1ns/1ps
`default_nettype none
`include "fp_issue_settings.svh"

module fp_credit_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic take,
    input  logic give,
    output logic has_credit
);

    localparam int CW = $clog2(`FP_CREDITS + 1);

    logic [CW-1:0] count;

    // take and give in the same cycle cancel out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= CW'(`FP_CREDITS);
        end else if (take && !give) begin
            count <= count - CW'(1);
        end else if (give && !take) begin
            count <= count + CW'(1);
        end
    end

    assign has_credit = (count != '0);

endmodule

`default_nettype wire

//--- fp_issue/fp_issue_ctrl.sv
// fp issue controller with the holding register and the accept, trap and issue state machine
`timescale 1ns/1ps
`default_nettype none

module fp_issue_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    input  logic [31:0]                  in_instr,
    input  fp_issue_pkg::fp_decode_t     dec,
    input  logic                         hazard,
    input  logic                         has_credit,
    input  logic                         out_ready,
    output logic                         in_ready,
    output logic [31:0]                  held_instr,
    output logic                         out_valid,
    output fp_issue_pkg::fp_issue_pkt_t  out_pkt,
    output logic                         trap_valid,
    output logic [31:0]                  trap_instr,
    output logic                         issue
);

    fp_issue_pkg::fp_issue_state_e state;
    fp_issue_pkg::fp_issue_state_e state_nxt;
    logic [31:0]                   word_q;

    ////////////////////
    // handshakes

    assign in_ready = (state == fp_issue_pkg::ST_EMPTY);

    // while empty the decoder sees the incoming word, so an illegal one goes straight to trap
    assign held_instr = in_ready ? in_instr : word_q;

    // hazard and credit only improve while held, so out_valid stays up until the transfer
    assign out_valid  = (state == fp_issue_pkg::ST_HELD) && !hazard && has_credit;
    assign issue      = out_valid && out_ready;
    assign trap_valid = (state == fp_issue_pkg::ST_TRAP);
    assign trap_instr = word_q;

    always_comb begin
        out_pkt.instr       = word_q;
        out_pkt.op_class    = dec.op_class;
        out_pkt.fmt         = dec.fmt;
        out_pkt.need_int    = dec.need_int;
        out_pkt.need_float  = dec.need_float;
        out_pkt.write_int   = dec.write_int;
        out_pkt.write_float = dec.write_float;
        out_pkt.accum_csr   = dec.accum_csr;
    end

    ////////////////////
    // state machine

    always_comb begin
        state_nxt = state;
        case (state)
            fp_issue_pkg::ST_EMPTY: begin
                if (in_valid) begin
                    state_nxt = dec.legal ? fp_issue_pkg::ST_HELD : fp_issue_pkg::ST_TRAP;
                end
            end
            fp_issue_pkg::ST_HELD: begin
                if (issue) begin
                    state_nxt = fp_issue_pkg::ST_EMPTY;
                end
            end
            fp_issue_pkg::ST_TRAP: state_nxt = fp_issue_pkg::ST_EMPTY;
            default:               state_nxt = fp_issue_pkg::ST_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= fp_issue_pkg::ST_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    // holding register
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            word_q <= in_instr;
        end
    end

endmodule

`default_nettype wire

//--- fp_issue/fp_issue_unit.sv
// fp issue unit top level joining the controller, decoder, scoreboard and credit counter
`timescale 1ns/1ps
`default_nettype none

module fp_issue_unit (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [31:0]                  in_instr,
    output logic                         out_valid,
    input  logic                         out_ready,
    output fp_issue_pkg::fp_issue_pkt_t  out_pkt,
    output logic                         trap_valid,
    output logic [31:0]                  trap_instr,
    input  logic                         wb_valid,
    input  fp_issue_pkg::fp_wb_t         wb
);

    logic [31:0]              held_instr;
    fp_issue_pkg::fp_decode_t dec;
    logic                     hazard;
    logic                     has_credit;
    logic                     issue;

    fp_issue_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .dec        (dec),
        .hazard     (hazard),
        .has_credit (has_credit),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .held_instr (held_instr),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .trap_valid (trap_valid),
        .trap_instr (trap_instr),
        .issue      (issue)
    );

    fp_instruction_decoder u_decoder (
        .instr (held_instr),
        .dec   (dec)
    );

    fp_scoreboard u_scoreboard (
        .clk      (clk),
        .arst_n   (arst_n),
        .instr    (held_instr),
        .dec      (dec),
        .issue    (issue),
        .wb_valid (wb_valid),
        .wb       (wb),
        .hazard   (hazard)
    );

    // every writeback frees one slot, float or not
    fp_credit_counter u_credits (
        .clk        (clk),
        .arst_n     (arst_n),
        .take       (issue),
        .give       (wb_valid),
        .has_credit (has_credit)
    );

endmodule

`default_nettype wire

//--- tests/fp_issue_sva.sv
// fp issue assertions on the output handshake, trap pulse and stream exclusion
`timescale 1ns/1ps
`default_nettype none

module fp_issue_sva (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        in_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input fp_issue_pkg::fp_issue_pkt_t out_pkt,
    input logic                        trap_valid
);

    // a stalled packet stays offered and unchanged
    property pkt_stable_p;
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pkt));
    endproperty

    property trap_pulse_p;
        @(posedge clk) disable iff (!arst_n)
        trap_valid |=> !trap_valid;
    endproperty

    property one_side_p;
        @(posedge clk) disable iff (!arst_n)
        !(in_ready && out_valid);
    endproperty

    pkt_stable_a: assert property (pkt_stable_p) else $error("out_pkt changed under back-pressure");
    trap_pulse_a: assert property (trap_pulse_p) else $error("trap_valid held two cycles");
    one_side_a:   assert property (one_side_p) else $error("in_ready and out_valid both high");

endmodule

bind fp_issue_unit fp_issue_sva sva_i (.*);

`default_nettype wire

//--- tests/fp_issue_tb.sv
// fp issue testbench running directed tests against a reference decode model
`timescale 1ns/1ps
`default_nettype none
`include "fp_issue_settings.svh"

module fp_issue_tb;

    localparam logic [6:0] OP_FP = 7'b1010011;
    localparam int RAND_OPS   = 40;
    localparam int OP_CYCLES  = 12;
    // directed ops plus the random stream and margin for the stall windows
    localparam int MAX_CYCLES = (20 + RAND_OPS) * OP_CYCLES + 200;

    logic clk;
    logic arst_n;
    logic in_valid;
    logic in_ready;
    logic [31:0] in_instr;
    logic out_valid;
    logic out_ready;
    fp_issue_pkg::fp_issue_pkt_t out_pkt;
    logic trap_valid;
    logic [31:0] trap_instr;
    logic wb_valid;
    fp_issue_pkg::fp_wb_t wb;

    fp_issue_pkg::fp_issue_pkt_t pkt_q[$];
    logic [31:0] trap_q[$];
    int trap_cycles;
    time last_pkt_time;
    time accept_time;
    int errors;
    int test_errors;
    int tests_run;
    int cycles;
    logic [31:0] lfsr_state;

    fp_issue_unit dut_i (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_instr(in_instr), .out_valid(out_valid), .out_ready(out_ready), .out_pkt(out_pkt),
        .trap_valid(trap_valid), .trap_instr(trap_instr), .wb_valid(wb_valid), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // monitor and timeout
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
        if (arst_n && out_valid && out_ready) begin
            pkt_q.push_back(out_pkt);
            last_pkt_time = $time;
        end
        if (arst_n && trap_valid) begin
            trap_q.push_back(trap_instr);
            trap_cycles = trap_cycles + 1;
        end
    end

    ////////////////////
    // reference model
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        r_type = {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic fp_issue_pkg::fp_decode_t ref_decode(input logic [31:0] w);
        fp_issue_pkg::fp_decode_t d;
        logic [4:0] f5;
        logic [1:0] fmt;
        logic [2:0] f3;
        logic [4:0] rs2;
        logic dbl;
        f5 = w[31:27];
        fmt = w[26:25];
        f3 = w[14:12];
        rs2 = w[24:20];
        dbl = (fmt == 2'b01);
        d = '0;
        d.op_class = fp_issue_pkg::OPC_OP;
        d.fmt = dbl ? fp_issue_pkg::FMT_D : fp_issue_pkg::FMT_S;
        case (w[6:0])
            7'b0000111, 7'b0100111: begin
                d.legal = (f3 == 3'b010) || (f3 == 3'b011);
                d.fmt = (f3 == 3'b011) ? fp_issue_pkg::FMT_D : fp_issue_pkg::FMT_S;
                d.need_int = 1'b1;
                if (w[5]) begin
                    d.op_class = fp_issue_pkg::OPC_STORE;
                    d.need_float = 1'b1;
                end else begin
                    d.op_class = fp_issue_pkg::OPC_LOAD;
                end
            end
            7'b1000011, 7'b1000111, 7'b1001011, 7'b1001111: begin
                d.legal = !fmt[1];
                d.op_class = fp_issue_pkg::OPC_FMA;
                d.need_float = 1'b1;
                d.uses_rs3 = 1'b1;
                d.accum_csr = dbl;
            end
            OP_FP: begin
                d.need_float = 1'b1;
                if (!fmt[1]) begin
                    case (f5)
                        5'b00000, 5'b00001, 5'b00010, 5'b00011: d.legal = 1'b1;
                        5'b01011: d.legal = (rs2 == 5'd0);
                        5'b00100: d.legal = (f3 <= 3'd2);
                        5'b00101: d.legal = (f3 <= 3'd1);
                        5'b10100: d.legal = (f3 <= 3'd2);
                        5'b11000: d.legal = (rs2 <= 5'd1);
                        5'b11010: d.legal = (rs2 <= 5'd1);
                        5'b11100: d.legal = (rs2 == 5'd0) && ((f3 == 3'd1) ||
                                            (f3 == 3'd0 && fmt == 2'b00));
                        5'b11110: d.legal = (rs2 == 5'd0) && (f3 == 3'd0) && (fmt == 2'b00);
                        5'b01000: d.legal = (fmt == 2'b00 && rs2 == 5'd1) ||
                                            (fmt == 2'b01 && rs2 == 5'd0);
                        default: d.legal = 1'b0;
                    endcase
                end
                d.write_int = (f5 == 5'b10100) || (f5 == 5'b11100) || (f5 == 5'b11000);
                // moves and converts from the integer side read no float
                if (f5 == 5'b11010 || f5 == 5'b11110) begin
                    d.need_int = 1'b1;
                    d.need_float = 1'b0;
                end
                d.accum_csr = (f5 == 5'b01000) ||
                              (dbl && (f5[4:2] == 3'b000 || f5 == 5'b01011 || f5 == 5'b00101 ||
                                       f5 == 5'b10100 || f5 == 5'b11000));
            end
            default: d.legal = 1'b0;
        endcase
        d.write_float = d.legal && (d.op_class != fp_issue_pkg::OPC_STORE) && !d.write_int;
        ref_decode = d;
    endfunction

    function automatic fp_issue_pkg::fp_issue_pkt_t expected_pkt(input logic [31:0] w);
        fp_issue_pkg::fp_decode_t d;
        fp_issue_pkg::fp_issue_pkt_t p;
        d = ref_decode(w);
        p.instr = w;
        p.op_class = d.op_class;
        p.fmt = d.fmt;
        p.need_int = d.need_int;
        p.need_float = d.need_float;
        p.write_int = d.write_int;
        p.write_float = d.write_float;
        p.accum_csr = d.accum_csr;
        expected_pkt = p;
    endfunction

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        rand_bits = r;
    endfunction

    ////////////////////
    // bus tasks
    task automatic send(input logic [31:0] w);
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= w;
        do @(posedge clk); while (!in_ready);
        accept_time = $time;
        in_valid <= 1'b0;
    endtask

    task automatic writeback(input logic [4:0] rd, input logic is_float);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb <= '{rd: rd, is_float: is_float};
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic receive_and_check(input logic [31:0] w);
        fp_issue_pkg::fp_issue_pkt_t got;
        while (pkt_q.size() == 0) @(posedge clk);
        got = pkt_q.pop_front();
        assert (got === expected_pkt(w)) else begin
            $display("[FAIL] %0t: packet %h for word %h, expected %h", $time, got, w,
                     expected_pkt(w));
            test_errors++;
        end
    endtask

    task automatic issue_and_retire(input logic [31:0] w);
        fp_issue_pkg::fp_decode_t d;
        d = ref_decode(w);
        send(w);
        receive_and_check(w);
        writeback(w[11:7], d.write_float);
    endtask

    task automatic expect_no_packet(input string what);
        repeat (5) @(posedge clk);
        assert (pkt_q.size() == 0) else begin
            $display("[FAIL] %0t: %s issued while it should be held", $time, what);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    ////////////////////
    // directed tests
    task automatic legal_decode_test();
        issue_and_retire(r_type(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, OP_FP));
        issue_and_retire({5'd7, 2'b01, 5'd6, 5'd5, 3'b000, 5'd4, 7'b1000011});
        issue_and_retire({12'd0, 5'd1, 3'b010, 5'd8, 7'b0000111});
        issue_and_retire({7'd0, 5'd9, 5'd2, 3'b011, 5'd8, 7'b0100111});
        issue_and_retire(r_type(7'b1010001, 5'd2, 5'd1, 3'b010, 5'd5, OP_FP));
        issue_and_retire(r_type(7'b1100000, 5'd0, 5'd3, 3'b000, 5'd6, OP_FP));
        issue_and_retire(r_type(7'b1110000, 5'd0, 5'd4, 3'b000, 5'd7, OP_FP));
        finish_test("legal_decode");
    endtask

    task automatic trap_one(input logic [31:0] w);
        logic [31:0] got_w;
        trap_cycles = 0;
        send(w);
        while (trap_q.size() == 0) @(posedge clk);
        repeat (3) @(posedge clk);
        got_w = trap_q.pop_front();
        assert (trap_cycles == 1 && got_w === w && pkt_q.size() == 0) else begin
            $display("[FAIL] %0t: word %h gave %0d trap cycles with word %h, %0d packets",
                     $time, w, trap_cycles, got_w, pkt_q.size());
            test_errors++;
        end
    endtask

    task automatic illegal_test();
        trap_one(r_type(7'b0111100, 5'd1, 5'd2, 3'b000, 5'd3, OP_FP));
        trap_one(r_type(7'b0000010, 5'd1, 5'd2, 3'b000, 5'd3, OP_FP));
        trap_one(32'h0020_80b3);
        finish_test("illegal_words");
    endtask

    task automatic raw_hazard_test();
        logic [31:0] mul_w;
        mul_w = r_type(7'b0001000, 5'd4, 5'd3, 3'b000, 5'd5, OP_FP);
        send(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, OP_FP));
        receive_and_check(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, OP_FP));
        send(mul_w);
        expect_no_packet("FMUL.S reading pending f3");
        writeback(5'd3, 1'b1);
        receive_and_check(mul_w);
        writeback(5'd5, 1'b1);
        send(r_type(7'b0000000, 5'd12, 5'd11, 3'b000, 5'd10, OP_FP));
        receive_and_check(r_type(7'b0000000, 5'd12, 5'd11, 3'b000, 5'd10, OP_FP));
        assert (last_pkt_time == accept_time + 10) else begin
            $display("[FAIL] %0t: unrelated FADD.S waited after accept", $time);
            test_errors++;
        end
        writeback(5'd10, 1'b1);
        finish_test("raw_hazard");
    endtask

    task automatic credit_test();
        logic [31:0] st_w;
        for (int i = 0; i < `FP_CREDITS; i++) begin
            send(r_type(7'b0000000, 5'd21, 5'd20, 3'b000, 5'(16 + i), OP_FP));
            receive_and_check(r_type(7'b0000000, 5'd21, 5'd20, 3'b000, 5'(16 + i), OP_FP));
        end
        st_w = {7'd0, 5'd22, 5'd25, 3'b010, 5'd0, 7'b0100111};
        send(st_w);
        expect_no_packet("store with no free slot");
        writeback(5'd0, 1'b0);
        receive_and_check(st_w);
        for (int i = 0; i < `FP_CREDITS; i++) begin
            writeback(5'(16 + i), 1'b1);
        end
        finish_test("credits");
    endtask

    task automatic backpressure_test();
        logic [31:0] w;
        fp_issue_pkg::fp_issue_pkt_t held;
        w = r_type(7'b0000000, 5'd28, 5'd27, 3'b000, 5'd26, OP_FP);
        @(posedge clk);
        out_ready <= 1'b0;
        send(w);
        do @(posedge clk); while (!out_valid);
        held = out_pkt;
        repeat (4) begin
            @(posedge clk);
            assert (out_pkt === held && !in_ready && out_valid) else begin
                $display("[FAIL] %0t: packet or in_ready moved under back-pressure", $time);
                test_errors++;
            end
        end
        out_ready <= 1'b1;
        receive_and_check(w);
        repeat (3) @(posedge clk);
        assert (pkt_q.size() == 0) else begin
            $display("[FAIL] %0t: packet transferred more than once", $time);
            test_errors++;
        end
        writeback(5'd26, 1'b1);
        finish_test("backpressure");
    endtask

    task automatic random_stream_test();
        logic [31:0] w;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rs3;
        int sel;
        for (int i = 0; i < RAND_OPS; i++) begin
            sel = int'(rand_bits(8)) % 10;
            rd = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            rs3 = 5'(rand_bits(5));
            case (sel)
                0: w = r_type(7'b0000000, rs2, rs1, 3'b000, rd, OP_FP);
                1: w = r_type(7'b0001001, rs2, rs1, 3'b000, rd, OP_FP);
                2: w = {rs3, 2'b00, rs2, rs1, 3'b000, rd, 7'b1000111};
                3: w = {12'd0, rs1, 3'b010, rd, 7'b0000111};
                4: w = {7'd0, rs2, rs1, 3'b011, rd, 7'b0100111};
                5: w = r_type(7'b1010000, rs2, rs1, 3'b010, rd, OP_FP);
                6: w = r_type(7'b1100001, 5'd1, rs1, 3'b000, rd, OP_FP);
                7: w = r_type(7'b0010001, rs2, rs1, 3'b001, rd, OP_FP);
                8: w = r_type(7'b0100001, 5'd0, rs1, 3'b000, rd, OP_FP);
                default: w = r_type(7'b0101101, 5'd0, rs1, 3'b000, rd, OP_FP);
            endcase
            issue_and_retire(w);
        end
        finish_test("random_stream");
    endtask

    initial begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        out_ready = 1'b1;
        wb_valid = 1'b0;
        wb = '0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        cycles = 0;
        trap_cycles = 0;
        lfsr_state = 32'h5db9;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        legal_decode_test();
        illegal_test();
        raw_hazard_test();
        credit_test();
        backpressure_test();
        random_stream_test();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/fp_issue_pkg.sv
hdl/fp_instruction_decoder.sv
hdl/fp_scoreboard.sv
hdl/fp_credit_counter.sv
fp_issue/fp_issue_ctrl.sv
fp_issue/fp_issue_unit.sv
tests/fp_issue_sva.sv
tests/fp_issue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fp_issue_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
